/* source/ooo_pkg.sv */
package ooo_pkg;

	// the reorder buffer sits outside this slice, so its geometry is fixed here
	localparam int tag_w = 4;
	localparam int rob_size = 16;

	typedef enum logic [6:0] {
		op_lui = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal = 7'b1101111,
		op_jalr = 7'b1100111,
		op_br = 7'b1100011,
		op_imm = 7'b0010011,
		op_reg = 7'b0110011
	} opcode_e;

	// encoded as {funct7[5], funct3} so reg/imm ops map straight across
	typedef enum logic [3:0] {
		alu_add = 4'b0000,
		alu_sll = 4'b0001,
		alu_xor = 4'b0100,
		alu_srl = 4'b0101,
		alu_or = 4'b0110,
		alu_and = 4'b0111,
		alu_sub = 4'b1000,
		alu_sra = 4'b1101
	} alu_op_e;

	// branch funct3 values
	typedef enum logic [2:0] {
		cmp_beq = 3'b000,
		cmp_bne = 3'b001,
		cmp_blt = 3'b100,
		cmp_bge = 3'b101,
		cmp_bltu = 3'b110,
		cmp_bgeu = 3'b111
	} cmp_op_e;

	// arithmetic funct3 values that need special handling in decode
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_sr = 3'b101;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} i_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} inst_u;

	// while busy, value[tag_w-1:0] is the producer tag
	typedef struct packed {
		logic busy;
		logic [31:0] value;
	} operand_t;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		inst_u inst;
		logic [31:0] pc;
		operand_t src1;
		operand_t src2;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] tag;
		operand_t op1;
		operand_t op2;
		alu_op_e alu_op;
		cmp_op_e cmp_op;
		logic use_cmp;
	} rs_entry_t;

	typedef struct packed {
		logic rdy;
		logic [31:0] data;
	} rob_bcast_t;

	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] front_tag;
		logic [tag_w-1:0] rear_tag;
		logic [tag_w-1:0] flush_tag;
	} flush_t;

	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] tag;
		logic [31:0] data;
	} result_t;

endpackage

/* source/issue_decode.sv */
`timescale 1ns/1ps

module issue_decode (
	input ooo_pkg::issue_t slot,
	input ooo_pkg::rob_bcast_t rob_bcast [ooo_pkg::rob_size],
	output ooo_pkg::rs_entry_t entry
);

	logic [31:0] word;
	logic [2:0] funct3;
	logic f7b5;
	logic [31:0] i_imm;
	logic [31:0] u_imm;
	logic [31:0] j_imm;
	ooo_pkg::operand_t src1_r;
	ooo_pkg::operand_t src2_r;

	// swap a busy tag for its data when the producer is already done
	function automatic ooo_pkg::operand_t resolve(input ooo_pkg::operand_t src);
		ooo_pkg::operand_t res;
		res = src;
		if (src.busy && rob_bcast[src.value[ooo_pkg::tag_w-1:0]].rdy) begin
			res.busy = 1'b0;
			res.value = rob_bcast[src.value[ooo_pkg::tag_w-1:0]].data;
		end
		return res;
	endfunction

	function automatic ooo_pkg::operand_t imm_operand(input logic [31:0] v);
		return '{busy: 1'b0, value: v};
	endfunction

	assign word = slot.inst;
	assign funct3 = slot.inst.r_view.funct3;
	assign f7b5 = slot.inst.r_view.funct7[5];
	assign i_imm = {{20{slot.inst.i_view.imm12[11]}}, slot.inst.i_view.imm12};
	assign u_imm = {word[31:12], 12'b0};
	assign j_imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

	always_comb begin
		src1_r = resolve(slot.src1);
		src2_r = resolve(slot.src2);
	end

	always_comb begin
		entry = '0;
		entry.valid = 1'b1;
		entry.tag = slot.tag;
		entry.alu_op = ooo_pkg::alu_add;
		entry.cmp_op = ooo_pkg::cmp_beq;
		entry.use_cmp = 1'b0;
		entry.op1 = src1_r;
		entry.op2 = src2_r;
		case (slot.inst.r_view.opcode)
			ooo_pkg::op_jal: begin
				entry.op1 = imm_operand(slot.pc);
				entry.op2 = imm_operand(j_imm);
			end
			ooo_pkg::op_jalr: begin
				entry.op2 = imm_operand(i_imm);
			end
			ooo_pkg::op_lui: begin
				entry.op1 = imm_operand(u_imm);
				entry.op2 = imm_operand(32'b0);
			end
			ooo_pkg::op_auipc: begin
				entry.op1 = imm_operand(slot.pc);
				entry.op2 = imm_operand(u_imm);
			end
			ooo_pkg::op_reg: begin
				if (funct3 == ooo_pkg::f3_slt) begin
					entry.use_cmp = 1'b1;
					entry.cmp_op = ooo_pkg::cmp_blt;
				end else if (funct3 == ooo_pkg::f3_sltu) begin
					entry.use_cmp = 1'b1;
					entry.cmp_op = ooo_pkg::cmp_bltu;
				end else begin
					// funct7[5] only means sub or sra
					entry.alu_op = ooo_pkg::alu_op_e'({f7b5 &
						(funct3 == ooo_pkg::f3_add || funct3 == ooo_pkg::f3_sr), funct3});
				end
			end
			ooo_pkg::op_imm: begin
				entry.op2 = imm_operand(i_imm);
				if (funct3 == ooo_pkg::f3_slt) begin
					entry.use_cmp = 1'b1;
					entry.cmp_op = ooo_pkg::cmp_blt;
				end else if (funct3 == ooo_pkg::f3_sltu) begin
					entry.use_cmp = 1'b1;
					entry.cmp_op = ooo_pkg::cmp_bltu;
				end else if (funct3 == ooo_pkg::f3_sll || funct3 == ooo_pkg::f3_sr) begin
					// shamt only, the upper imm bits select srai
					entry.op2 = imm_operand({27'b0, slot.inst.i_view.imm12[4:0]});
					entry.alu_op = ooo_pkg::alu_op_e'({f7b5 & (funct3 == ooo_pkg::f3_sr), funct3});
				end else begin
					entry.alu_op = ooo_pkg::alu_op_e'({1'b0, funct3});
				end
			end
			ooo_pkg::op_br: begin
				entry.use_cmp = 1'b1;
				entry.cmp_op = ooo_pkg::cmp_op_e'(funct3);
			end
			default: ;
		endcase
	end

endmodule

/* source/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station #(
	parameter int rs_size = 8
) (
	input logic clk,
	input logic rst,
	input ooo_pkg::flush_t flush,
	input ooo_pkg::rob_bcast_t rob_bcast [ooo_pkg::rob_size],
	input logic load0,
	input logic load1,
	input logic [$clog2(rs_size)-1:0] alloc0,
	input logic [$clog2(rs_size)-1:0] alloc1,
	input ooo_pkg::rs_entry_t entry0,
	input ooo_pkg::rs_entry_t entry1,
	input logic disp_valid,
	input logic [$clog2(rs_size)-1:0] disp_idx,
	output ooo_pkg::rs_entry_t entries [rs_size],
	output ooo_pkg::rs_entry_t disp_entry
);

	// surviving window is front_tag up to flush_tag, wrapping
	function automatic logic survives(input logic [ooo_pkg::tag_w-1:0] t);
		logic [ooo_pkg::tag_w-1:0] after_rear;
		after_rear = flush.rear_tag + 1'b1;
		// flushing just past the youngest op keeps everything
		if (after_rear == flush.flush_tag) begin
			return 1'b1;
		end
		if (flush.front_tag <= flush.flush_tag) begin
			return (t >= flush.front_tag) && (t < flush.flush_tag);
		end
		return (t >= flush.front_tag) || (t < flush.flush_tag);
	endfunction

	assign disp_entry = entries[disp_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rs_size; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else begin
			// operand capture from the rob broadcast
			for (int i = 0; i < rs_size; i++) begin
				if (entries[i].valid && entries[i].op1.busy &&
					rob_bcast[entries[i].op1.value[ooo_pkg::tag_w-1:0]].rdy) begin
					entries[i].op1.busy <= 1'b0;
					entries[i].op1.value <= rob_bcast[entries[i].op1.value[ooo_pkg::tag_w-1:0]].data;
				end
				if (entries[i].valid && entries[i].op2.busy &&
					rob_bcast[entries[i].op2.value[ooo_pkg::tag_w-1:0]].rdy) begin
					entries[i].op2.busy <= 1'b0;
					entries[i].op2.value <= rob_bcast[entries[i].op2.value[ooo_pkg::tag_w-1:0]].data;
				end
			end

			if (flush.valid) begin
				// loads in a flush cycle are dropped
				for (int i = 0; i < rs_size; i++) begin
					if (!survives(entries[i].tag)) begin
						entries[i].valid <= 1'b0;
					end
				end
			end else begin
				if (load0) begin
					entries[alloc0] <= entry0;
				end
				if (load1) begin
					entries[alloc1] <= entry1;
				end
			end

			// dispatched entry leaves the station
			if (disp_valid) begin
				entries[disp_idx].valid <= 1'b0;
			end
		end
	end

	// allocation from rs_control must only hit free slots
	load_free_slot: assert property (@(posedge clk) disable iff (rst)
		(load0 |-> !entries[alloc0].valid) and (load1 |-> !entries[alloc1].valid));

	load_distinct: assert property (@(posedge clk) disable iff (rst)
		(load0 && load1) |-> (alloc0 != alloc1));

endmodule

/* source/rs_control.sv */
`timescale 1ns/1ps

module rs_control #(
	parameter int rs_size = 8
) (
	input logic clk,
	input logic rst,
	input logic [1:0] issue_valid,
	input ooo_pkg::rs_entry_t entries [rs_size],
	output logic [1:0] accept,
	output logic load0,
	output logic load1,
	output logic [$clog2(rs_size)-1:0] alloc0,
	output logic [$clog2(rs_size)-1:0] alloc1,
	output logic disp_valid,
	output logic [$clog2(rs_size)-1:0] disp_idx,
	output logic [$clog2(rs_size+1)-1:0] num_free
);

	localparam int idx_w = $clog2(rs_size);
	localparam int cnt_w = $clog2(rs_size + 1);

	logic found0;
	logic found1;

	always_comb begin
		num_free = '0;
		found0 = 1'b0;
		found1 = 1'b0;
		alloc0 = '0;
		alloc1 = '0;
		disp_valid = 1'b0;
		disp_idx = '0;
		for (int i = 0; i < rs_size; i++) begin
			if (!entries[i].valid) begin
				num_free = num_free + 1'b1;
				// two lowest free slots
				if (!found0) begin
					found0 = 1'b1;
					alloc0 = idx_w'(i);
				end else if (!found1) begin
					found1 = 1'b1;
					alloc1 = idx_w'(i);
				end
			end else if (!entries[i].op1.busy && !entries[i].op2.busy && !disp_valid) begin
				disp_valid = 1'b1;
				disp_idx = idx_w'(i);
			end
		end
	end

	assign accept[0] = (num_free >= cnt_w'(1));
	assign accept[1] = (num_free >= cnt_w'(2));
	assign load0 = issue_valid[0] && accept[0];
	assign load1 = issue_valid[1] && accept[1];

	// a dispatched entry is gone from the station one cycle later
	disp_cleared: assert property (@(posedge clk) disable iff (rst)
		disp_valid |=> !(disp_valid && disp_idx == $past(disp_idx)));

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input ooo_pkg::rs_entry_t disp_entry,
	output ooo_pkg::result_t result
);

	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] alu_out;
	logic cmp_out;
	logic res_valid;
	logic [ooo_pkg::tag_w-1:0] res_tag;
	logic [31:0] res_data;

	assign a = disp_entry.op1.value;
	assign b = disp_entry.op2.value;

	always_comb begin
		case (disp_entry.alu_op)
			ooo_pkg::alu_sub: alu_out = a - b;
			ooo_pkg::alu_sll: alu_out = a << b[4:0];
			ooo_pkg::alu_xor: alu_out = a ^ b;
			ooo_pkg::alu_srl: alu_out = a >> b[4:0];
			ooo_pkg::alu_sra: alu_out = $unsigned($signed(a) >>> b[4:0]);
			ooo_pkg::alu_or: alu_out = a | b;
			ooo_pkg::alu_and: alu_out = a & b;
			default: alu_out = a + b;
		endcase
	end

	always_comb begin
		case (disp_entry.cmp_op)
			ooo_pkg::cmp_bne: cmp_out = (a != b);
			ooo_pkg::cmp_blt: cmp_out = ($signed(a) < $signed(b));
			ooo_pkg::cmp_bge: cmp_out = ($signed(a) >= $signed(b));
			ooo_pkg::cmp_bltu: cmp_out = (a < b);
			ooo_pkg::cmp_bgeu: cmp_out = (a >= b);
			default: cmp_out = (a == b);
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= disp_valid;
		end
	end

	always_ff @(posedge clk) begin
		res_tag <= disp_entry.tag;
		res_data <= disp_entry.use_cmp ? {31'b0, cmp_out} : alu_out;
	end

	assign result = '{valid: res_valid, tag: res_tag, data: res_data};

	// a busy operand still holds a tag, never data to compute with
	disp_operands_ready: assert property (@(posedge clk) disable iff (rst)
		disp_valid |-> (disp_entry.valid && !disp_entry.op1.busy && !disp_entry.op2.busy));

endmodule

/* source/issue_exec_slice.sv */
`timescale 1ns/1ps

module issue_exec_slice #(
	parameter int rs_size = 8
) (
	input logic clk,
	input logic rst,
	input logic [1:0] issue_valid,
	input ooo_pkg::issue_t issue [2],
	input ooo_pkg::rob_bcast_t rob_bcast [ooo_pkg::rob_size],
	input ooo_pkg::flush_t flush,
	output logic [1:0] accept,
	output logic [$clog2(rs_size+1)-1:0] num_free,
	output ooo_pkg::result_t result
);

	ooo_pkg::rs_entry_t dec_entry0;
	ooo_pkg::rs_entry_t dec_entry1;
	ooo_pkg::rs_entry_t entries [rs_size];
	ooo_pkg::rs_entry_t disp_entry;
	logic load0;
	logic load1;
	logic [$clog2(rs_size)-1:0] alloc0;
	logic [$clog2(rs_size)-1:0] alloc1;
	logic disp_valid;
	logic [$clog2(rs_size)-1:0] disp_idx;

	issue_decode dec0 (
		.slot(issue[0]),
		.rob_bcast(rob_bcast),
		.entry(dec_entry0)
	);

	issue_decode dec1 (
		.slot(issue[1]),
		.rob_bcast(rob_bcast),
		.entry(dec_entry1)
	);

	reservation_station #(.rs_size(rs_size)) rs0 (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.rob_bcast(rob_bcast),
		.load0(load0),
		.load1(load1),
		.alloc0(alloc0),
		.alloc1(alloc1),
		.entry0(dec_entry0),
		.entry1(dec_entry1),
		.disp_valid(disp_valid),
		.disp_idx(disp_idx),
		.entries(entries),
		.disp_entry(disp_entry)
	);

	rs_control #(.rs_size(rs_size)) ctrl0 (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.entries(entries),
		.accept(accept),
		.load0(load0),
		.load1(load1),
		.alloc0(alloc0),
		.alloc1(alloc1),
		.disp_valid(disp_valid),
		.disp_idx(disp_idx),
		.num_free(num_free)
	);

	exec_unit exec0 (
		.clk(clk),
		.rst(rst),
		.disp_valid(disp_valid),
		.disp_entry(disp_entry),
		.result(result)
	);

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 4
) (
	output logic clk
);

	// free running, starts low
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

/* verif/issue_exec_slice_tb.sv */
`timescale 1ns/1ps

module issue_exec_slice_tb;

	localparam int rs_size = 8;
	localparam int n_issues = 24 + 16 + 8 + 5 + 32 + 6;
	// an op can sit behind a full station and a late broadcast
	localparam int lat_bound = 24;
	localparam int max_cycles = n_issues * lat_bound + 100;

	typedef struct packed {
		ooo_pkg::issue_t op;
		logic [31:0] exp;
		logic armed;
		logic [ooo_pkg::tag_w-1:0] prod;
	} queued_op_t;

	logic clk;
	logic rst;
	logic [1:0] issue_valid;
	ooo_pkg::issue_t issue [2];
	ooo_pkg::rob_bcast_t bcast [ooo_pkg::rob_size];
	ooo_pkg::flush_t flush;
	logic [1:0] accept;
	logic [$clog2(rs_size+1)-1:0] num_free;
	ooo_pkg::result_t result;

	// scoreboard, indexed by tag
	logic [31:0] sb_exp [ooo_pkg::rob_size];
	logic sb_pend [ooo_pkg::rob_size];
	logic sb_armed [ooo_pkg::rob_size];
	logic [ooo_pkg::tag_w-1:0] sb_prod [ooo_pkg::rob_size];
	logic [31:0] prod_data [ooo_pkg::rob_size];

	queued_op_t op_q [$];
	integer seed;
	int errors;
	int checks;
	int loaded;
	int results;
	int cycles;
	logic track_free;
	logic saw_full;
	logic [ooo_pkg::tag_w-1:0] next_tag;

	tb_clock #(.period(4)) clk0 (.clk(clk));

	issue_exec_slice #(.rs_size(rs_size)) dut0 (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue(issue),
		.rob_bcast(bcast),
		.flush(flush),
		.accept(accept),
		.num_free(num_free),
		.result(result)
	);

	// RV32I meaning of the word, jumps give pc or rs1 plus the immediate
	function automatic logic [31:0] ref_exec(input logic [31:0] inst, input logic [31:0] pc,
		input logic [31:0] x, input logic [31:0] y);
		logic [2:0] f3;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] b;
		logic signed [31:0] sx;
		logic signed [31:0] sy;
		logic signed [31:0] sb;
		logic [31:0] res;
		f3 = inst[14:12];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_u = {inst[31:12], 12'h000};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		b = (inst[6:0] == 7'b0110011) ? y : imm_i;
		sx = x;
		sy = y;
		sb = b;
		res = 32'h0;
		case (inst[6:0])
			7'b0110111: res = imm_u;
			7'b0010111: res = pc + imm_u;
			7'b1101111: res = pc + imm_j;
			7'b1100111: res = x + imm_i;
			7'b1100011: begin
				case (f3)
					3'b000: res = {31'b0, x == y};
					3'b001: res = {31'b0, x != y};
					3'b100: res = {31'b0, sx < sy};
					3'b101: res = {31'b0, sx >= sy};
					3'b110: res = {31'b0, x < y};
					default: res = {31'b0, x >= y};
				endcase
			end
			default: begin
				// register and immediate forms share funct3
				case (f3)
					3'b000: res = (inst[5] && inst[30]) ? x - b : x + b;
					3'b001: res = x << b[4:0];
					3'b010: res = {31'b0, sx < sb};
					3'b011: res = {31'b0, x < b};
					3'b100: res = x ^ b;
					3'b101: begin
						if (inst[30]) begin
							res = sx >>> b[4:0];
						end else begin
							res = x >> b[4:0];
						end
					end
					3'b110: res = x | b;
					default: res = x & b;
				endcase
			end
		endcase
		return res;
	endfunction

	// funct3 values 0,1,4,5,6,7
	function automatic logic [2:0] pick_f3();
		int r;
		r = $unsigned($random(seed)) % 6;
		return (r < 2) ? 3'(r) : 3'(r + 2);
	endfunction

	// kind 0 arith, 1 compare, 2 jump/upper, 3 two registers, 4 any of 0..2
	function automatic logic [31:0] gen_inst(input int kind);
		logic [31:0] r;
		logic [2:0] f3;
		logic [11:0] imm;
		logic [6:0] f7;
		logic [31:0] w;
		int k;
		r = $random(seed);
		f3 = pick_f3();
		imm = r[31:20];
		f7 = (r[1] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
		k = (kind == 4) ? $unsigned($random(seed)) % 3 : kind;
		w = {f7, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
		case (k)
			0: begin
				if (!r[0]) begin
					if (f3 == 3'b001 || f3 == 3'b101) begin
						imm = {f7, r[24:20]};
					end
					w = {imm, r[19:15], f3, r[11:7], 7'b0010011};
				end
			end
			1: begin
				case (r[2:0])
					3'd0, 3'd1: w = {7'h00, r[24:20], r[19:15], 2'b01, r[0], r[11:7], 7'b0110011};
					3'd2, 3'd3: w = {imm, r[19:15], 2'b01, r[0], r[11:7], 7'b0010011};
					default: w = {r[31:25], r[24:20], r[19:15], f3, r[11:7], 7'b1100011};
				endcase
			end
			2: begin
				case (r[1:0])
					2'd0: w = {r[31:12], r[11:7], 7'b1101111};
					2'd1: w = {imm, r[19:15], 3'b000, r[11:7], 7'b1100111};
					2'd2: w = {r[31:12], r[11:7], 7'b0110111};
					default: w = {r[31:12], r[11:7], 7'b0010111};
				endcase
			end
			default: begin
				if (!r[0]) begin
					w = {r[31:25], r[24:20], r[19:15], f3, r[11:7], 7'b1100011};
				end
			end
		endcase
		return w;
	endfunction

	function automatic logic in_window(input logic [3:0] t, input logic [3:0] front,
		input logic [3:0] stop);
		if (front <= stop) begin
			return (t >= front) && (t < stop);
		end
		return (t >= front) || (t < stop);
	endfunction

	// busy sources wait on producer prod and take prod_data once it broadcasts
	task automatic add_op(input logic [3:0] tag, input int kind, input logic busy_a,
		input logic busy_b, input logic [3:0] prod);
		queued_op_t q;
		logic [31:0] word;
		logic [31:0] pc;
		logic [31:0] v1;
		logic [31:0] v2;
		word = gen_inst(kind);
		pc = $random(seed);
		pc[1:0] = 2'b00;
		v1 = busy_a ? prod_data[prod] : $random(seed);
		v2 = busy_b ? prod_data[prod] : $random(seed);
		// equal operands now and then for eq and ge
		if (!busy_b && ($random(seed) & 3) == 0) begin
			v2 = v1;
		end
		q.op.tag = tag;
		q.op.inst = ooo_pkg::inst_u'(word);
		q.op.pc = pc;
		q.op.src1.busy = busy_a;
		q.op.src1.value = busy_a ? 32'(prod) : v1;
		q.op.src2.busy = busy_b;
		q.op.src2.value = busy_b ? 32'(prod) : v2;
		q.exp = ref_exec(word, pc, v1, v2);
		q.armed = !(busy_a || busy_b);
		q.prod = prod;
		op_q.push_back(q);
	endtask

	task automatic add_ready(input int kind, input int count);
		for (int i = 0; i < count; i++) begin
			add_op(next_tag, kind, 1'b0, 1'b0, 4'd0);
			next_tag++;
		end
	endtask

	task automatic check_levels();
		int exp_free;
		exp_free = rs_size - (loaded - results - (result.valid ? 1 : 0));
		if (num_free == 0) begin
			saw_full = 1'b1;
		end
		checks += 2;
		assert (num_free == exp_free) else begin
			$display("CHECK FAILED at %0t: num_free %0d, expected %0d", $time, num_free, exp_free);
			errors++;
		end
		assert (accept == {exp_free >= 2, exp_free >= 1}) else begin
			$display("CHECK FAILED at %0t: accept %b with %0d free", $time, accept, exp_free);
			errors++;
		end
	endtask

	// drives queued ops into the slots that accept allows
	task automatic run_issue();
		queued_op_t q;
		while (op_q.size() > 0) begin
			@(negedge clk);
			issue_valid = 2'b00;
			if (track_free) begin
				check_levels();
			end
			for (int s = 0; s < 2; s++) begin
				if (accept[s] && op_q.size() > 0 && !sb_pend[op_q[0].op.tag]) begin
					q = op_q.pop_front();
					issue[s] = q.op;
					issue_valid[s] = 1'b1;
					sb_exp[q.op.tag] = q.exp;
					// a producer that already broadcast is bypassed in decode
					sb_armed[q.op.tag] = q.armed || bcast[q.prod].rdy;
					sb_prod[q.op.tag] = q.prod;
					sb_pend[q.op.tag] = 1'b1;
					loaded++;
				end
			end
		end
		@(negedge clk);
		issue_valid = 2'b00;
	endtask

	task automatic broadcast(input logic [3:0] prod);
		@(negedge clk);
		bcast[prod].rdy = 1'b1;
		bcast[prod].data = prod_data[prod];
		for (int t = 0; t < ooo_pkg::rob_size; t++) begin
			if (sb_pend[t] && !sb_armed[t] && sb_prod[t] == prod) begin
				sb_armed[t] = 1'b1;
			end
		end
	endtask

	task automatic clear_bcast();
		for (int t = 0; t < ooo_pkg::rob_size; t++) begin
			bcast[t] = '0;
			prod_data[t] = $random(seed);
		end
	endtask

	task automatic wait_drain();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(negedge clk);
			busy = 1'b0;
			for (int t = 0; t < ooo_pkg::rob_size; t++) begin
				if (sb_pend[t]) begin
					busy = 1'b1;
				end
			end
		end
	endtask

	task automatic report_test(input int n, input string name, input int err0);
		$display("test %0d %s: done, %0d errors", n, name, errors - err0);
	endtask

	// compares every result against the scoreboard
	always @(posedge clk) begin
		if (!rst && result.valid) begin
			results++;
			checks++;
			assert (sb_pend[result.tag]) else begin
				$display("unexpected result at %0t: tag %0d has no outstanding op",
					$time, result.tag);
				errors++;
			end
			if (sb_pend[result.tag]) begin
				assert (sb_armed[result.tag]) else begin
					$display("early result at %0t: tag %0d finished before its operand arrived",
						$time, result.tag);
					errors++;
				end
				assert (result.data == sb_exp[result.tag]) else begin
					$display("CHECK FAILED at %0t: tag %0d result %h, expected %h",
						$time, result.tag, result.data, sb_exp[result.tag]);
					errors++;
				end
				sb_pend[result.tag] = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int err0;
		int survivors;
		seed = 32'hf76e;
		errors = 0;
		checks = 0;
		loaded = 0;
		results = 0;
		cycles = 0;
		track_free = 1'b1;
		saw_full = 1'b0;
		next_tag = '0;
		rst = 1'b1;
		issue_valid = 2'b00;
		issue[0] = '0;
		issue[1] = '0;
		flush = '0;
		for (int t = 0; t < ooo_pkg::rob_size; t++) begin
			sb_exp[t] = '0;
			sb_pend[t] = 1'b0;
			sb_armed[t] = 1'b0;
			sb_prod[t] = '0;
		end
		clear_bcast();
		repeat (4) @(negedge clk);
		rst = 1'b0;

		err0 = errors;
		add_ready(0, 24);
		run_issue();
		wait_drain();
		report_test(1, "arithmetic and shifts", err0);

		err0 = errors;
		add_ready(1, 16);
		run_issue();
		wait_drain();
		report_test(2, "slt, sltu and branches", err0);

		err0 = errors;
		add_ready(2, 8);
		run_issue();
		wait_drain();
		report_test(3, "jal, jalr, lui and auipc", err0);

		// tags 0..3 wait on producers 8..11, tag 4 hits the decode bypass
		err0 = errors;
		clear_bcast();
		for (int i = 0; i < 4; i++) begin
			add_op(4'(i), 3, 1'b1, (i % 2) == 0, 4'(8 + i));
		end
		broadcast(4'd12);
		add_op(4'd4, 3, 1'b1, 1'b0, 4'd12);
		run_issue();
		repeat (6) @(negedge clk);
		for (int i = 3; i >= 0; i--) begin
			broadcast(4'(8 + i));
			repeat (2) @(negedge clk);
		end
		wait_drain();
		report_test(4, "busy operands", err0);

		// every other op waits, so the station fills before producer 13 arrives
		err0 = errors;
		clear_bcast();
		saw_full = 1'b0;
		for (int i = 0; i < 32; i++) begin
			if (i % 2 == 0) begin
				add_op(next_tag, 3, 1'b1, 1'b0, 4'd13);
			end else begin
				add_op(next_tag, 4, 1'b0, 1'b0, 4'd0);
			end
			next_tag++;
		end
		fork
			run_issue();
			begin
				repeat (24) @(negedge clk);
				broadcast(4'd13);
			end
		join
		wait_drain();
		checks++;
		assert (saw_full) else begin
			$display("station never reported full during the dual issue test");
			errors++;
		end
		report_test(5, "dual issue until full", err0);

		// window 14..0 survives, 1..3 are flushed
		err0 = errors;
		clear_bcast();
		track_free = 1'b0;
		for (int i = 0; i < 6; i++) begin
			add_op(4'(14 + i), 3, 1'b1, 1'b0, 4'd12);
		end
		run_issue();
		@(negedge clk);
		flush = '{valid: 1'b1, front_tag: 4'd14, rear_tag: 4'd3, flush_tag: 4'd1};
		survivors = 0;
		for (int t = 0; t < ooo_pkg::rob_size; t++) begin
			if (sb_pend[t] && in_window(4'(t), 4'd14, 4'd1)) begin
				survivors++;
			end else begin
				sb_pend[t] = 1'b0;
			end
		end
		@(negedge clk);
		flush.valid = 1'b0;
		checks++;
		assert (num_free == rs_size - survivors) else begin
			$display("CHECK FAILED at %0t: num_free %0d after flush, expected %0d",
				$time, num_free, rs_size - survivors);
			errors++;
		end
		repeat (6) @(negedge clk);
		broadcast(4'd12);
		wait_drain();
		repeat (4) @(negedge clk);
		report_test(6, "flush by tag window", err0);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* issue_exec_slice.f */
source/ooo_pkg.sv
source/issue_decode.sv
source/reservation_station.sv
source/rs_control.sv
source/exec_unit.sv
source/issue_exec_slice.sv
verif/tb_clock.sv
verif/issue_exec_slice_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= issue_exec_slice_tb
FILELIST ?= issue_exec_slice.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= Errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
